/* logic/udp_proto_pkg.sv */
// UDP protocol definitions
// Stream beat types, Ethernet/IPv4/UDP header layout and the header
// records passed between the parser, the reply generator and the transmitter
`default_nettype none

package udp_proto_pkg;

    // Byte n of a frame sits at beat n/8, lane n%8
    typedef logic [63:0] frame_word_t;
    typedef logic [7:0]  frame_keep_t;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // 42 header bytes span beats 0 to 5
    localparam int HDR_BEATS    = 6;
    localparam int PAYLOAD_BEAT = 5;
    localparam int PAYLOAD_LANE = 2;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    typedef struct packed {
        mac_addr_t   src_mac;
        ip_addr_t    src_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] ip_len;
        logic [15:0] udp_len;
    } udp_rx_hdr_t;

    typedef struct packed {
        mac_addr_t   dst_mac;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        logic [15:0] ip_csum;
    } udp_tx_hdr_t;

    // Lane 0 moves to the top byte and back
    function automatic frame_word_t byte_swap(frame_word_t w);
        frame_word_t r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = w[8*(7-i) +: 8];
        end
        return r;
    endfunction

endpackage

`default_nettype wire

/* logic/echo_cfg_pkg.sv */
// Echo board configuration
// Local addresses, echo port, reply TTL and payload buffer size
`default_nettype none

package echo_cfg_pkg;

    // Locally administered address
    localparam udp_proto_pkg::mac_addr_t LOCAL_MAC = 48'h02_00_00_00_00_00;

    // 192.168.1.128
    localparam udp_proto_pkg::ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    localparam udp_proto_pkg::udp_port_t ECHO_PORT = 16'd1234;

    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Payload buffer in beats
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire

/* logic/frame_stream_if.sv */
// Frame stream link
// One 64-bit beat per handshake with lane enables and end-of-frame flag
`default_nettype none

interface frame_stream_if;

    udp_proto_pkg::frame_word_t data;
    udp_proto_pkg::frame_keep_t keep;
    logic                       valid;
    logic                       ready;
    logic                       last;

    modport source (
        output data,
        output keep,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  keep,
        input  valid,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

/* logic/udp_hdr_parser.sv */
// UDP header parser
// Captures the Ethernet, IPv4 and UDP header from beats 0 to 5,
// filters on type, protocol, local IP and echo port, then passes the
// header on and forwards the payload beats of accepted frames
`default_nettype none

module udp_hdr_parser (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_proto_pkg::frame_word_t rx_data,
    input  udp_proto_pkg::frame_keep_t rx_keep,
    input  logic                       rx_valid,
    output logic                       rx_ready,
    input  logic                       rx_last,
    output udp_proto_pkg::udp_rx_hdr_t hdr,
    output logic                       hdr_valid,
    input  logic                       hdr_ready,
    frame_stream_if.source             pay
);

    udp_proto_pkg::frame_word_t rx_net;
    logic [2:0]                 beat_cnt;
    logic                       keep_frame;
    logic                       at_split;
    logic                       past_hdr;
    logic                       hdr_free;
    logic                       match;
    logic                       rx_fire;

    // Captured header fields
    udp_proto_pkg::mac_addr_t   src_mac;
    logic [15:0]                eth_type;
    logic [7:0]                 ver_ihl;
    logic [7:0]                 ip_proto;
    logic [15:0]                ip_len;
    udp_proto_pkg::ip_addr_t    src_ip;
    udp_proto_pkg::ip_addr_t    dst_ip;
    udp_proto_pkg::udp_port_t   src_port;
    udp_proto_pkg::udp_port_t   dst_port;
    logic [15:0]                udp_len;

    // Network byte order, first byte of the beat on top
    assign rx_net = udp_proto_pkg::byte_swap(rx_data);

    assign at_split = beat_cnt == 3'(udp_proto_pkg::PAYLOAD_BEAT);
    assign past_hdr = beat_cnt == 3'(udp_proto_pkg::HDR_BEATS);
    assign hdr_free = !hdr_valid || hdr_ready;

    // Fields up to beat 4 are all registered when beat 5 arrives
    assign match = eth_type == udp_proto_pkg::ETHERTYPE_IPV4
                && ver_ihl == udp_proto_pkg::IP_VER_IHL
                && ip_proto == udp_proto_pkg::IP_PROTO_UDP
                && dst_ip == echo_cfg_pkg::LOCAL_IP
                && dst_port == echo_cfg_pkg::ECHO_PORT;

    always_comb begin
        rx_ready  = 1'b1;
        pay.valid = 1'b0;
        if (at_split && match) begin
            // Header slot and FIFO both needed
            rx_ready  = hdr_free && pay.ready;
            pay.valid = rx_valid && hdr_free;
        end else if (past_hdr && keep_frame) begin
            rx_ready  = pay.ready;
            pay.valid = rx_valid;
        end
    end

    assign pay.data = rx_data;
    assign pay.keep = rx_keep;
    assign pay.last = rx_last;

    assign rx_fire = rx_valid && rx_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt   <= '0;
            keep_frame <= 1'b0;
            hdr_valid  <= 1'b0;
        end else begin
            if (hdr_valid && hdr_ready) begin
                hdr_valid <= 1'b0;
            end
            if (rx_fire) begin
                if (rx_last) begin
                    beat_cnt   <= '0;
                    keep_frame <= 1'b0;
                end else begin
                    if (!past_hdr) begin
                        beat_cnt <= beat_cnt + 3'd1;
                    end
                    if (at_split) begin
                        keep_frame <= match;
                    end
                end
                if (at_split && match) begin
                    hdr_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_fire) begin
            case (beat_cnt)
                3'd0: src_mac[47:32] <= rx_net[15:0];
                3'd1: begin
                    src_mac[31:0] <= rx_net[63:32];
                    eth_type      <= rx_net[31:16];
                    ver_ihl       <= rx_net[15:8];
                end
                3'd2: begin
                    ip_len   <= rx_net[63:48];
                    ip_proto <= rx_net[7:0];
                end
                3'd3: begin
                    src_ip         <= rx_net[47:16];
                    dst_ip[31:16]  <= rx_net[15:0];
                end
                3'd4: begin
                    dst_ip[15:0] <= rx_net[63:48];
                    src_port     <= rx_net[47:32];
                    dst_port     <= rx_net[31:16];
                    udp_len      <= rx_net[15:0];
                end
                default: ;
            endcase
            if (at_split && match) begin
                hdr.src_mac  <= src_mac;
                hdr.src_ip   <= src_ip;
                hdr.src_port <= src_port;
                hdr.dst_port <= dst_port;
                hdr.ip_len   <= ip_len;
                hdr.udp_len  <= udp_len;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/reply_hdr_gen.sv */
// Reply header generator
// Swaps addresses and ports of a parsed header and computes the
// IPv4 header checksum of the reply, holding one header at a time
`default_nettype none

module reply_hdr_gen (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_proto_pkg::udp_rx_hdr_t rx_hdr,
    input  logic                       rx_hdr_valid,
    output logic                       rx_hdr_ready,
    output udp_proto_pkg::udp_tx_hdr_t tx_hdr,
    output logic                       tx_hdr_valid,
    input  logic                       tx_hdr_ready
);

    logic [19:0] sum;
    logic [16:0] fold;
    logic [15:0] csum;
    logic        load;

    assign rx_hdr_ready = !tx_hdr_valid || tx_hdr_ready;
    assign load         = rx_hdr_valid && rx_hdr_ready;

    // Identification, flags and checksum words are zero
    always_comb begin
        sum = 20'({udp_proto_pkg::IP_VER_IHL, 8'h00})
            + 20'(rx_hdr.ip_len)
            + 20'({echo_cfg_pkg::REPLY_TTL, udp_proto_pkg::IP_PROTO_UDP})
            + 20'(echo_cfg_pkg::LOCAL_IP[31:16])
            + 20'(echo_cfg_pkg::LOCAL_IP[15:0])
            + 20'(rx_hdr.src_ip[31:16])
            + 20'(rx_hdr.src_ip[15:0]);
        // Two folds cover seven words
        fold = 17'(sum[15:0]) + 17'(sum[19:16]);
        csum = ~(fold[15:0] + 16'(fold[16]));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tx_hdr.dst_mac  <= rx_hdr.src_mac;
            tx_hdr.src_ip   <= echo_cfg_pkg::LOCAL_IP;
            tx_hdr.dst_ip   <= rx_hdr.src_ip;
            tx_hdr.src_port <= rx_hdr.dst_port;
            tx_hdr.dst_port <= rx_hdr.src_port;
            tx_hdr.ip_len   <= rx_hdr.ip_len;
            tx_hdr.udp_len  <= rx_hdr.udp_len;
            tx_hdr.ip_csum  <= csum;
        end
    end

endmodule

`default_nettype wire

/* logic/echo_payload_fifo.sv */
// Payload FIFO
// Circular buffer of stream beats with keep and last
// Ready drops when full, a written beat shows at the output next cycle
`default_nettype none

module echo_payload_fifo (
    input  logic           clk,
    input  logic           rst,
    frame_stream_if.sink   wr,
    frame_stream_if.source rd
);

    udp_proto_pkg::frame_word_t       data_mem [echo_cfg_pkg::FIFO_DEPTH];
    udp_proto_pkg::frame_keep_t       keep_mem [echo_cfg_pkg::FIFO_DEPTH];
    logic                             last_mem [echo_cfg_pkg::FIFO_DEPTH];
    logic [echo_cfg_pkg::FIFO_AW-1:0] wr_ptr;
    logic [echo_cfg_pkg::FIFO_AW-1:0] rd_ptr;
    logic [echo_cfg_pkg::FIFO_AW:0]   count;
    logic                             do_wr;
    logic                             do_rd;

    assign wr.ready = count != echo_cfg_pkg::FIFO_DEPTH;
    assign rd.valid = count != '0;

    assign rd.data = data_mem[rd_ptr];
    assign rd.keep = keep_mem[rd_ptr];
    assign rd.last = last_mem[rd_ptr];

    assign do_wr = wr.valid && wr.ready;
    assign do_rd = rd.valid && rd.ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            data_mem[wr_ptr] <= wr.data;
            keep_mem[wr_ptr] <= wr.keep;
            last_mem[wr_ptr] <= wr.last;
        end
    end

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/reply_frame_tx.sv */
// Reply frame transmitter
// Sends header beats 0 to 4 from the reply header, then the buffered
// payload up to last, clearing the UDP checksum on the first payload beat
// First payload byte of each reply is latched onto the LEDs
`default_nettype none

module reply_frame_tx (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_proto_pkg::udp_tx_hdr_t hdr,
    input  logic                       hdr_valid,
    output logic                       hdr_ready,
    frame_stream_if.sink               pay,
    output udp_proto_pkg::frame_word_t tx_data,
    output udp_proto_pkg::frame_keep_t tx_keep,
    output logic                       tx_valid,
    input  logic                       tx_ready,
    output logic                       tx_last,
    output logic [7:0]                 led
);

    logic [2:0]                 beat;
    logic                       in_payload;
    logic                       first_pay;
    logic                       tx_fire;
    udp_proto_pkg::frame_word_t hdr_net;

    assign in_payload = beat == 3'(udp_proto_pkg::PAYLOAD_BEAT);
    assign tx_fire    = tx_valid && tx_ready;

    // Header slot is released with the last header beat
    assign hdr_ready = tx_fire && beat == 3'(udp_proto_pkg::PAYLOAD_BEAT - 1);
    assign pay.ready = in_payload && tx_ready;

    // Header beats in network byte order
    always_comb begin
        case (beat)
            3'd0: hdr_net = {hdr.dst_mac, echo_cfg_pkg::LOCAL_MAC[47:32]};
            3'd1: hdr_net = {echo_cfg_pkg::LOCAL_MAC[31:0], udp_proto_pkg::ETHERTYPE_IPV4,
                             udp_proto_pkg::IP_VER_IHL, 8'h00};
            3'd2: hdr_net = {hdr.ip_len, 32'h0000_0000,
                             echo_cfg_pkg::REPLY_TTL, udp_proto_pkg::IP_PROTO_UDP};
            3'd3: hdr_net = {hdr.ip_csum, hdr.src_ip, hdr.dst_ip[31:16]};
            default: hdr_net = {hdr.dst_ip[15:0], hdr.src_port, hdr.dst_port, hdr.udp_len};
        endcase
    end

    always_comb begin
        if (in_payload) begin
            tx_valid = pay.valid;
            tx_data  = pay.data;
            tx_keep  = pay.keep;
            tx_last  = pay.last;
            // Zero UDP checksum ahead of the payload
            if (first_pay) begin
                tx_data[8*udp_proto_pkg::PAYLOAD_LANE-1:0] = '0;
            end
        end else begin
            tx_valid = hdr_valid;
            tx_data  = udp_proto_pkg::byte_swap(hdr_net);
            tx_keep  = '1;
            tx_last  = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat      <= '0;
            first_pay <= 1'b0;
            led       <= '0;
        end else if (tx_fire) begin
            if (!in_payload) begin
                beat      <= beat + 3'd1;
                first_pay <= beat == 3'(udp_proto_pkg::PAYLOAD_BEAT - 1);
            end else begin
                first_pay <= 1'b0;
                if (first_pay) begin
                    led <= pay.data[8*udp_proto_pkg::PAYLOAD_LANE +: 8];
                end
                if (pay.last) begin
                    beat <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/udp_echo_core.sv */
// UDP echo core
// Parses incoming UDP/IPv4 frames, buffers the payload of frames sent to
// the echo port and returns them with swapped addresses and ports
`default_nettype none

module udp_echo_core (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_proto_pkg::frame_word_t rx_data,
    input  udp_proto_pkg::frame_keep_t rx_keep,
    input  logic                       rx_valid,
    output logic                       rx_ready,
    input  logic                       rx_last,
    output udp_proto_pkg::frame_word_t tx_data,
    output udp_proto_pkg::frame_keep_t tx_keep,
    output logic                       tx_valid,
    input  logic                       tx_ready,
    output logic                       tx_last,
    output logic [7:0]                 led
);

    frame_stream_if pay_in ();
    frame_stream_if pay_out ();

    udp_proto_pkg::udp_rx_hdr_t rx_hdr;
    logic                       rx_hdr_valid;
    logic                       rx_hdr_ready;
    udp_proto_pkg::udp_tx_hdr_t tx_hdr;
    logic                       tx_hdr_valid;
    logic                       tx_hdr_ready;

    udp_hdr_parser i_parser (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_keep   (rx_keep),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .rx_last   (rx_last),
        .hdr       (rx_hdr),
        .hdr_valid (rx_hdr_valid),
        .hdr_ready (rx_hdr_ready),
        .pay       (pay_in)
    );

    reply_hdr_gen i_hdr_gen (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready)
    );

    echo_payload_fifo i_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (pay_in),
        .rd  (pay_out)
    );

    reply_frame_tx i_tx (
        .clk       (clk),
        .rst       (rst),
        .hdr       (tx_hdr),
        .hdr_valid (tx_hdr_valid),
        .hdr_ready (tx_hdr_ready),
        .pay       (pay_out),
        .tx_data   (tx_data),
        .tx_keep   (tx_keep),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_last   (tx_last),
        .led       (led)
    );

endmodule

`default_nettype wire

/* bench/udp_echo_asserts.sv */
// Reply stream checks for the UDP echo core
// Stall stability, idle output after reset and LED update timing
`default_nettype none

module udp_echo_asserts (
    input logic                       clk,
    input logic                       rst,
    input udp_proto_pkg::frame_word_t tx_data,
    input logic                       tx_valid,
    input logic                       tx_ready,
    input logic                       tx_last,
    input logic [7:0]                 led
);

    int         fail_count = 0;
    logic [2:0] beat;
    logic       first_fire;

    // First payload beat follows five header beats
    assign first_fire = tx_valid && tx_ready && beat == 3'd5;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else if (tx_valid && tx_ready) begin
            if (tx_last) begin
                beat <= '0;
            end else if (beat != 3'd7) begin
                beat <= beat + 3'd1;
            end
        end
    end

    stall_stable: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else begin
            $error("tx beat changed while stalled");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge clk) rst |=> !tx_valid)
        else begin
            $error("tx_valid high in the cycle after reset");
            fail_count++;
        end

    led_update: assert property (@(posedge clk) disable iff (rst)
        !$stable(led) |-> $past(first_fire))
        else begin
            $error("led changed without a first payload beat");
            fail_count++;
        end

endmodule

`default_nettype wire

/* bench/udp_echo_tb.sv */
// UDP echo core testbench
// Sends a table of Ethernet/IPv4/UDP frames with LFSR payloads, applies
// random back-pressure to the reply stream and checks every reply beat
// and the LED byte against replies built from the protocol rules
`default_nettype none

module udp_echo_tb;

    localparam int CLK_HALF       = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_CASES      = 12;
    localparam int DRAIN_CYCLES   = 20;
    // 42 header bytes, so payload starts in beat 5
    localparam int FIRST_PAY_BEAT = 42 / 8;

    typedef struct packed {
        udp_proto_pkg::mac_addr_t src_mac;
        udp_proto_pkg::ip_addr_t  src_ip;
        udp_proto_pkg::ip_addr_t  dst_ip;
        udp_proto_pkg::udp_port_t src_port;
        udp_proto_pkg::udp_port_t dst_port;
        logic [15:0]              eth_type;
        logic [7:0]               proto;
        logic [15:0]              pay_len;
        logic                     echo;
    } frame_case_t;

    logic                       clk;
    logic                       rst;
    udp_proto_pkg::frame_word_t rx_data;
    udp_proto_pkg::frame_keep_t rx_keep;
    logic                       rx_valid;
    logic                       rx_ready;
    logic                       rx_last;
    udp_proto_pkg::frame_word_t tx_data;
    udp_proto_pkg::frame_keep_t tx_keep;
    logic                       tx_valid;
    logic                       tx_ready;
    logic                       tx_last;
    logic [7:0]                 led;

    logic [15:0]                lfsr;
    logic [7:0]                 frame_bytes [$];
    udp_proto_pkg::frame_word_t in_data [$];
    udp_proto_pkg::frame_keep_t in_keep [$];
    logic                       in_last [$];
    udp_proto_pkg::frame_word_t exp_data [$];
    udp_proto_pkg::frame_keep_t exp_keep [$];
    logic                       exp_last [$];
    logic [7:0]                 led_q [$];

    // src MAC, src IP, dst IP, src port, dst port, ethertype, protocol, length, echo
    frame_case_t cases [NUM_CASES] = '{
        '{48'h001b213a4c01, 32'h0a000005, echo_cfg_pkg::LOCAL_IP, 16'd5000,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd17, 16'd6, 1'b1},
        '{48'h001b213a4c01, 32'h0a000005, echo_cfg_pkg::LOCAL_IP, 16'd5001,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd17, 16'd7, 1'b1},
        '{48'h001b213a4c02, 32'hac100409, echo_cfg_pkg::LOCAL_IP, 16'd6000,
          16'd1235, 16'h0800, 8'd17, 16'd20, 1'b0},
        '{48'h001b213a4c02, 32'hac100409, echo_cfg_pkg::LOCAL_IP, 16'd6001,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd17, 16'd14, 1'b1},
        '{48'h001b213a4c03, 32'h0a000007, 32'hc0a80181, 16'd7000,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd17, 16'd10, 1'b0},
        '{48'h001b213a4c03, 32'h0a000007, echo_cfg_pkg::LOCAL_IP, 16'd7001,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd17, 16'd300, 1'b1},
        '{48'h001b213a4c04, 32'hc0a80102, echo_cfg_pkg::LOCAL_IP, 16'd40000,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd6, 16'd16, 1'b0},
        '{48'h001b213a4c04, 32'hc0a80102, echo_cfg_pkg::LOCAL_IP, 16'd40001,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd17, 16'd33, 1'b1},
        '{48'h001b213a4c05, 32'hc0a80103, echo_cfg_pkg::LOCAL_IP, 16'd53,
          echo_cfg_pkg::ECHO_PORT, 16'h86dd, 8'd17, 16'd12, 1'b0},
        '{48'h001b213a4c05, 32'hc0a80103, echo_cfg_pkg::LOCAL_IP, 16'd54,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd17, 16'd1, 1'b1},
        '{48'h001b213a4c06, 32'hac10ffee, echo_cfg_pkg::LOCAL_IP, 16'd65535,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd17, 16'd64, 1'b1},
        '{48'h001b213a4c06, 32'hac10ffee, echo_cfg_pkg::LOCAL_IP, 16'd1024,
          echo_cfg_pkg::ECHO_PORT, 16'h0800, 8'd17, 16'd9, 1'b1}
    };

    udp_echo_core i_dut (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_keep  (rx_keep),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_last  (rx_last),
        .tx_data  (tx_data),
        .tx_keep  (tx_keep),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_last  (tx_last),
        .led      (led)
    );

    bind udp_echo_core udp_echo_asserts i_asserts (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_last  (tx_last),
        .led      (led)
    );

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(string name, udp_proto_pkg::frame_word_t got,
                              udp_proto_pkg::frame_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_keep(string name, udp_proto_pkg::frame_keep_t got,
                              udp_proto_pkg::frame_keep_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_last(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_led(logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: led got %h expected %h", $time, got, exp));
        end
    endtask

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] lfsr_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_bit();
        end
        return b;
    endfunction

    function automatic udp_proto_pkg::frame_word_t lane_mask(udp_proto_pkg::frame_keep_t k);
        udp_proto_pkg::frame_word_t m;
        for (int l = 0; l < 8; l++) begin
            m[8*l +: 8] = {8{k[l]}};
        end
        return m;
    endfunction

    // Network order, most significant byte first
    task automatic put_field(logic [47:0] v, int n);
        for (int i = n - 1; i >= 0; i--) begin
            frame_bytes.push_back(v[8*i +: 8]);
        end
    endtask

    task automatic put_header(
        udp_proto_pkg::mac_addr_t dst_mac, udp_proto_pkg::mac_addr_t src_mac,
        logic [15:0] eth_type, logic [31:0] id_flags, logic [7:0] ttl, logic [7:0] proto,
        udp_proto_pkg::ip_addr_t src_ip, udp_proto_pkg::ip_addr_t dst_ip,
        udp_proto_pkg::udp_port_t src_port, udp_proto_pkg::udp_port_t dst_port,
        logic [15:0] pay_len, logic [15:0] udp_csum
    );
        logic [31:0] sum;
        frame_bytes.delete();
        put_field(dst_mac, 6);
        put_field(src_mac, 6);
        put_field(48'(eth_type), 2);
        put_field(48'h4500, 2);
        put_field(48'(16'd28 + pay_len), 2);
        put_field(48'(id_flags), 4);
        put_field(48'({ttl, proto}), 2);
        put_field(48'h0000, 2);
        put_field(48'(src_ip), 4);
        put_field(48'(dst_ip), 4);
        put_field(48'(src_port), 2);
        put_field(48'(dst_port), 2);
        put_field(48'(16'd8 + pay_len), 2);
        put_field(48'(udp_csum), 2);
        // IPv4 header is bytes 14 to 33, checksum field at 24 and 25
        sum = '0;
        for (int i = 14; i < 34; i += 2) begin
            sum = sum + 32'({frame_bytes[i], frame_bytes[i+1]});
        end
        while (sum[31:16] != 16'h0000) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        frame_bytes[24] = ~sum[15:8];
        frame_bytes[25] = ~sum[7:0];
    endtask

    task automatic queue_beats(logic to_exp);
        int                         nbeats;
        udp_proto_pkg::frame_word_t w;
        udp_proto_pkg::frame_keep_t k;
        nbeats = (frame_bytes.size() + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            w = '0;
            k = '0;
            for (int l = 0; l < 8; l++) begin
                if (8*b + l < frame_bytes.size()) begin
                    w[8*l +: 8] = frame_bytes[8*b + l];
                    k[l]        = 1'b1;
                end
            end
            if (to_exp) begin
                exp_data.push_back(w);
                exp_keep.push_back(k);
                exp_last.push_back(b == nbeats - 1);
            end else begin
                in_data.push_back(w);
                in_keep.push_back(k);
                in_last.push_back(b == nbeats - 1);
            end
        end
    endtask

    task automatic build_case(frame_case_t c);
        logic [7:0] pay [$];
        for (int i = 0; i < int'(c.pay_len); i++) begin
            pay.push_back(lfsr_byte());
        end
        // Request with a nonzero id, DF set and a nonzero UDP checksum
        put_header(echo_cfg_pkg::LOCAL_MAC, c.src_mac, c.eth_type, 32'h1c46_4000, 8'd32,
                   c.proto, c.src_ip, c.dst_ip, c.src_port, c.dst_port, c.pay_len, 16'ha5c3);
        foreach (pay[i]) frame_bytes.push_back(pay[i]);
        queue_beats(1'b0);
        if (c.echo) begin
            put_header(c.src_mac, echo_cfg_pkg::LOCAL_MAC, 16'h0800, 32'h0,
                       echo_cfg_pkg::REPLY_TTL, 8'd17, echo_cfg_pkg::LOCAL_IP, c.src_ip,
                       c.dst_port, c.src_port, c.pay_len, 16'h0000);
            foreach (pay[i]) frame_bytes.push_back(pay[i]);
            queue_beats(1'b1);
            led_q.push_back(pay[0]);
        end
    endtask

    task automatic send_beat(udp_proto_pkg::frame_word_t d, udp_proto_pkg::frame_keep_t k,
                             logic l);
        rx_data  <= d;
        rx_keep  <= k;
        rx_last  <= l;
        rx_valid <= 1'b1;
        @(negedge clk);
        while (!rx_ready) @(negedge clk);
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        rst      = 1'b1;
        rx_data  = '0;
        rx_keep  = '0;
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        lfsr     = 16'd20;
        for (int i = 0; i < NUM_CASES; i++) begin
            build_case(cases[i]);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // Frames back to back, no idle beats between them
        for (int i = 0; i < in_data.size(); i++) begin
            send_beat(in_data[i], in_keep[i], in_last[i]);
        end
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
        while (exp_data.size() != 0) @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (i_dut.i_asserts.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("Bound assertion checks failed during the run");
        end
    end

    // Random tx_ready, high three cycles in four on average
    initial begin : backpressure
        logic b0;
        logic b1;
        tx_ready = 1'b0;
        @(posedge clk);
        while (rst) @(posedge clk);
        forever begin
            b0 = lfsr_bit();
            b1 = lfsr_bit();
            tx_ready <= b0 | b1;
            @(posedge clk);
        end
    end

    initial begin : monitor
        logic [7:0]                 exp_led;
        int                         rep_beat;
        udp_proto_pkg::frame_keep_t k;
        exp_led  = 8'h00;
        rep_beat = 0;
        @(negedge clk);
        while (rst) @(negedge clk);
        forever begin
            if (i_dut.i_asserts.fail_count != 0) begin
                abort_run("A bound assertion on the reply stream failed");
            end
            check_led(led, exp_led);
            if (tx_valid && tx_ready) begin
                if (exp_data.size() == 0) begin
                    abort_run("Reply beat sent while no reply was expected");
                end else begin
                    k = exp_keep.pop_front();
                    check_keep("tx_keep", tx_keep, k);
                    check_word("tx_data", tx_data & lane_mask(k), exp_data.pop_front());
                    check_last("tx_last", tx_last, exp_last.pop_front());
                    if (rep_beat == FIRST_PAY_BEAT) begin
                        exp_led = led_q.pop_front();
                    end
                    rep_beat = tx_last ? 0 : rep_beat + 1;
                end
            end
            @(negedge clk);
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_CASES * 64) @(posedge clk);
        abort_run("Timeout: replies did not complete within the cycle budget");
    end

endmodule

`default_nettype wire

/* sim.f */
logic/udp_proto_pkg.sv
logic/echo_cfg_pkg.sv
logic/frame_stream_if.sv
logic/udp_hdr_parser.sv
logic/reply_hdr_gen.sv
logic/echo_payload_fifo.sv
logic/reply_frame_tx.sv
logic/udp_echo_core.sv
bench/udp_echo_asserts.sv
bench/udp_echo_tb.sv

/* Makefile */
SIM  := obj_dir/Vudp_echo_tb
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

$(SIM): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module udp_echo_tb -f sim.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
